//--- common/lane_if.sv
// Lane interface with job and result handshakes and its modports
interface lane_if
  import modexp_pkg::*;
();

  // Job handshake, dispatcher to lane
  logic job_val;
  logic job_rdy;
  job_t job;

  // Result handshake, lane to collector
  logic res_val;
  logic res_rdy;
  fe_t  res;

  modport dispatch (output job_val, output job, input job_rdy);

  modport lane (
    input  job_val, input job, output job_rdy,
    output res_val, output res, input res_rdy
  );

  modport collect (input res_val, input res, output res_rdy);

endinterface

//--- common/modexp_defines.svh
// Field width, key width, prime modulus and lane count macros
`ifndef MODEXP_DEFINES_SVH
`define MODEXP_DEFINES_SVH

// Field element width in bits
`define FE_BITS 16

// Exponent width in bits
`define KEY_BITS 16

// Largest 16-bit prime
`define FIELD_P 65521

// Parallel exponentiation lanes
`define NUM_LANES 4

`endif

//--- common/modexp_pkg.sv
// Field element, key, job and lane index types
`include "modexp_defines.svh"

package modexp_pkg;

  // Element of GF(FIELD_P), also the result payload
  typedef logic [`FE_BITS-1:0] fe_t;

  // Exponent
  typedef logic [`KEY_BITS-1:0] key_t;

  // One exponentiation job
  typedef struct packed {
    fe_t  base;  // Must already be below FIELD_P
    key_t key;
  } job_t;

  // Round-robin pointer over the lanes
  typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

endpackage

//--- exp_lane/exp_lane.sv
// Square-and-multiply exponentiation lane with leading-zero key scan
`include "modexp_defines.svh"

module exp_lane
  import modexp_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  lane_if.lane io_lane
);

  localparam int LEFT_BITS = $clog2(`KEY_BITS + 1);

  typedef enum logic [2:0] {IDLE, SCAN, SQR, MUL, DONE} state_t;

  state_t               state;
  fe_t                  base;
  fe_t                  acc;        // Running power
  key_t                 key;        // Current bit sits at the top
  logic [LEFT_BITS-1:0] bits_left;  // Unprocessed key bits
  logic                 key_msb;
  logic                 mul_wait;   // Multiplier started, waiting for done
  logic                 mul_start;
  logic                 mul_done;
  fe_t                  mul_b;
  fe_t                  mul_prod;

  assign key_msb   = key[`KEY_BITS-1];
  assign mul_start = ((state == SQR) || (state == MUL)) && !mul_wait;
  assign mul_b     = (state == MUL) ? base : acc;  // Square or times base

  assign io_lane.job_rdy = (state == IDLE);
  assign io_lane.res_val = (state == DONE);
  assign io_lane.res     = acc;

  // Sequencer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= IDLE;
      mul_wait <= 1'b0;
    end else begin
      case (state)
        IDLE: if (io_lane.job_val) state <= SCAN;
        SCAN: begin
          if (bits_left == '0) begin
            state <= DONE;  // All-zero key leaves acc at one
          end else if (key_msb) begin
            state <= (bits_left == LEFT_BITS'(1)) ? DONE : SQR;
          end
        end
        SQR: begin
          if (mul_start) mul_wait <= 1'b1;
          if (mul_done) begin
            mul_wait <= 1'b0;
            if (key_msb) state <= MUL;
            else if (bits_left == LEFT_BITS'(1)) state <= DONE;
          end
        end
        MUL: begin
          if (mul_start) mul_wait <= 1'b1;
          if (mul_done) begin
            mul_wait <= 1'b0;
            state    <= (bits_left == LEFT_BITS'(1)) ? DONE : SQR;
          end
        end
        DONE: if (io_lane.res_rdy) state <= IDLE;  // Hold result until taken
        default: state <= IDLE;
      endcase
    end
  end

  // Operands, key shifting and accumulator
  always_ff @(posedge i_clk) begin
    case (state)
      IDLE: begin
        if (io_lane.job_val) begin
          base      <= io_lane.job.base;
          key       <= io_lane.job.key;
          acc       <= fe_t'(1);
          bits_left <= LEFT_BITS'(`KEY_BITS);
        end
      end
      SCAN: begin
        if (bits_left != '0) begin
          key       <= key << 1;
          bits_left <= bits_left - 1'b1;
          if (key_msb) acc <= base;  // First set bit
        end
      end
      SQR: begin
        if (mul_done) begin
          acc <= mul_prod;
          if (!key_msb) begin  // Set bit shifts after its multiply
            key       <= key << 1;
            bits_left <= bits_left - 1'b1;
          end
        end
      end
      MUL: begin
        if (mul_done) begin
          acc       <= mul_prod;
          key       <= key << 1;
          bits_left <= bits_left - 1'b1;
        end
      end
      default: ;
    endcase
  end

  mod_mul i_mod_mul (
    .i_clk   ( i_clk     ),
    .i_rst   ( i_rst     ),
    .i_start ( mul_start ),
    .i_a     ( acc       ),
    .i_b     ( mul_b     ),
    .o_done  ( mul_done  ),
    .o_prod  ( mul_prod  )
  );

endmodule

//--- exp_lane/mod_mul.sv
// Bit-serial interleaved modular multiplier over GF(FIELD_P)
`include "modexp_defines.svh"

module mod_mul
  import modexp_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_start,
  input  fe_t  i_a,
  input  fe_t  i_b,
  output logic o_done,
  output fe_t  o_prod
);

  localparam int CNT_BITS = $clog2(`FE_BITS + 1);
  localparam logic [`FE_BITS:0] P_EXT = `FIELD_P;

  fe_t                 a_op;  // Multiplicand
  fe_t                 b_sh;  // Multiplier, consumed from the top
  fe_t                 acc;   // Partial sum, always below FIELD_P
  logic                busy;
  logic [CNT_BITS-1:0] cnt;
  logic [`FE_BITS:0]   dbl;
  logic [`FE_BITS:0]   dbl_red;
  logic [`FE_BITS:0]   sum;
  logic [`FE_BITS:0]   sum_red;

  // One step computes acc = 2*acc (+ a) mod P with one conditional subtract per stage
  always_comb begin
    dbl     = {acc, 1'b0};
    dbl_red = (dbl >= P_EXT) ? dbl - P_EXT : dbl;
    sum     = dbl_red + (b_sh[`FE_BITS-1] ? {1'b0, a_op} : '0);
    sum_red = (sum >= P_EXT) ? sum - P_EXT : sum;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        cnt  <= CNT_BITS'(`FE_BITS);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_BITS'(1)) begin  // Last bit of b
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      a_op <= i_a;
      b_sh <= i_b;
      acc  <= '0;
    end else if (busy) begin
      acc  <= sum_red[`FE_BITS-1:0];
      b_sh <= b_sh << 1;
    end
  end

  assign o_prod = acc;

endmodule

//--- hdl/job_dispatch.sv
// Job input buffer and round-robin hand-out to the lanes
`include "modexp_defines.svh"

module job_dispatch
  import modexp_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  output logic     o_rdy,
  input  job_t     i_job,
  lane_if.dispatch o_lanes [`NUM_LANES]
);

  lane_idx_t              ptr;       // Lane that gets the next job
  logic                   buf_val;
  logic                   buf_rdy;
  job_t                   buf_job;
  logic [`NUM_LANES-1:0]  lane_rdy;

  stream_skid #(
    .T ( job_t )
  ) i_job_skid (
    .i_clk ( i_clk   ),
    .i_rst ( i_rst   ),
    .i_val ( i_val   ),
    .o_rdy ( o_rdy   ),
    .i_dat ( i_job   ),
    .o_val ( buf_val ),
    .i_rdy ( buf_rdy ),
    .o_dat ( buf_job )
  );

  // Only the pointed lane sees a valid job
  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    assign o_lanes[g].job_val = buf_val && (ptr == lane_idx_t'(g));
    assign o_lanes[g].job     = buf_job;
    assign lane_rdy[g]        = o_lanes[g].job_rdy;
  end

  assign buf_rdy = lane_rdy[ptr];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= '0;
    end else if (buf_val && buf_rdy) begin
      ptr <= (ptr == lane_idx_t'(`NUM_LANES - 1)) ? '0 : ptr + 1'b1;
    end
  end

endmodule

//--- hdl/modexp_engine.sv
// Top level with the job dispatcher, the exponentiation lanes and the result collector
`include "modexp_defines.svh"

module modexp_engine
  import modexp_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  // Job input
  input  logic i_val,
  output logic o_rdy,
  input  fe_t  i_base,
  input  key_t i_key,
  // Result output, base ** key mod FIELD_P
  output logic o_val,
  input  logic i_rdy,
  output fe_t  o_res
);

  job_t in_job;

  lane_if lanes [`NUM_LANES] ();

  assign in_job = '{base: i_base, key: i_key};

  job_dispatch i_job_dispatch (
    .i_clk   ( i_clk  ),
    .i_rst   ( i_rst  ),
    .i_val   ( i_val  ),
    .o_rdy   ( o_rdy  ),
    .i_job   ( in_job ),
    .o_lanes ( lanes  )
  );

  // Each lane owns its multiplier
  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    exp_lane i_exp_lane (
      .i_clk   ( i_clk    ),
      .i_rst   ( i_rst    ),
      .io_lane ( lanes[g] )
    );
  end

  result_collect i_result_collect (
    .i_clk   ( i_clk ),
    .i_rst   ( i_rst ),
    .i_lanes ( lanes ),
    .o_val   ( o_val ),
    .i_rdy   ( i_rdy ),
    .o_res   ( o_res )
  );

endmodule

//--- hdl/result_collect.sv
// Round-robin result draining from the lanes into the output buffer
`include "modexp_defines.svh"

module result_collect
  import modexp_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  lane_if.collect i_lanes [`NUM_LANES],
  output logic    o_val,
  input  logic    i_rdy,
  output fe_t     o_res
);

  lane_idx_t              ptr;  // Same order as the dispatcher
  logic [`NUM_LANES-1:0]  lane_val;
  fe_t                    lane_res [`NUM_LANES];
  logic                   skid_rdy;
  logic                   take;

  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    assign lane_val[g]        = i_lanes[g].res_val;
    assign lane_res[g]        = i_lanes[g].res;
    assign i_lanes[g].res_rdy = skid_rdy && (ptr == lane_idx_t'(g));
  end

  assign take = lane_val[ptr] && skid_rdy;

  stream_skid #(
    .T ( fe_t )
  ) i_res_skid (
    .i_clk ( i_clk         ),
    .i_rst ( i_rst         ),
    .i_val ( lane_val[ptr] ),
    .o_rdy ( skid_rdy      ),
    .i_dat ( lane_res[ptr] ),
    .o_val ( o_val         ),
    .i_rdy ( i_rdy         ),
    .o_dat ( o_res         )
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= '0;
    end else if (take) begin
      ptr <= (ptr == lane_idx_t'(`NUM_LANES - 1)) ? '0 : ptr + 1'b1;
    end
  end

endmodule

//--- hdl/stream_skid.sv
// Two-entry valid/ready buffer with a type-parameterized payload
module stream_skid
  import modexp_pkg::*;
#(
  parameter type T = fe_t
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  output logic o_rdy,
  input  T     i_dat,
  output logic o_val,
  input  logic i_rdy,
  output T     o_dat
);

  T mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign push  = i_val && o_rdy;
  assign pop   = o_val && i_rdy;
  assign o_rdy = (count != 2'd2);  // Depends on state only, not on i_rdy
  assign o_val = (count != 2'd0);
  assign o_dat = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= i_dat;
  end

endmodule

//--- sim.f
+incdir+common
common/modexp_pkg.sv
common/lane_if.sv
hdl/stream_skid.sv
exp_lane/mod_mul.sv
exp_lane/exp_lane.sv
hdl/job_dispatch.sv
hdl/result_collect.sv
hdl/modexp_engine.sv
testbench/tb_modexp.sv

//--- testbench/tb_modexp.sv
// Testbench for modexp_engine with reference model, result checker and watchdog
`include "modexp_defines.svh"

module tb_modexp
  import modexp_pkg::*;
;

  localparam int N_DIRECTED = 23;   // Edge and extreme operand jobs
  localparam int N_RANDOM   = 200;  // Jobs per random phase
  localparam int TOTAL_JOBS = N_DIRECTED + 2 * N_RANDOM;

  logic clk;
  logic i_rst;
  logic i_val;
  logic o_rdy;
  fe_t  i_base;
  key_t i_key;
  logic o_val;
  logic i_rdy;
  fe_t  o_res;

  fe_t         exp_q [$];  // Expected results in job order
  job_t        job_q [$];  // Matching jobs, for error lines
  logic [31:0] job_seed;
  logic [31:0] rdy_seed;
  logic        bp_on;      // Random back-pressure on i_rdy

  modexp_engine i_modexp_engine (
    .i_clk  ( clk    ),
    .i_rst  ( i_rst  ),
    .i_val  ( i_val  ),
    .o_rdy  ( o_rdy  ),
    .i_base ( i_base ),
    .i_key  ( i_key  ),
    .o_val  ( o_val  ),
    .i_rdy  ( i_rdy  ),
    .o_res  ( o_res  )
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Square-and-multiply over the whole key, MSB first
  function automatic fe_t ref_modexp(input fe_t b, input key_t k);
    logic [31:0] r;
    logic [31:0] x;
    r = 32'd1;
    x = 32'(b);
    for (int i = `KEY_BITS - 1; i >= 0; i--) begin
      r = (r * r) % `FIELD_P;
      if (k[i]) r = (r * x) % `FIELD_P;
    end
    return fe_t'(r);
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  // Called at edge+1, returns at edge+1 after the transfer
  task automatic send_job(input fe_t b, input key_t k);
    logic accepted;
    accepted = 1'b0;
    i_val    = 1'b1;
    i_base   = b;
    i_key    = k;
    while (!accepted) begin
      accepted = o_rdy;  // Stable until the next edge
      @(posedge clk);
      #1;
    end
    exp_q.push_back(ref_modexp(b, k));
    job_q.push_back('{base: b, key: k});
    i_val = 1'b0;
  endtask

  task automatic send_random_job();
    fe_t  b;
    key_t k;
    job_seed = xorshift32(job_seed);
    b        = fe_t'(job_seed % `FIELD_P);
    job_seed = xorshift32(job_seed);
    k        = key_t'(job_seed);
    send_job(b, k);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Output ready pattern
  always begin
    @(posedge clk);
    #1;
    rdy_seed = xorshift32(rdy_seed);
    i_rdy    = bp_on ? (rdy_seed[7:4] > 4'd5) : 1'b1;
  end

  // Compare at the falling edge, where outputs and i_rdy are settled
  always @(negedge clk) begin : compare_results
    fe_t  expv;
    job_t jobv;
    if (!i_rst && o_val && i_rdy) begin
      assert (exp_q.size() > 0)
        else report_fail("A result came out while no job was pending");
      expv = exp_q.pop_front();
      jobv = job_q.pop_front();
      assert (o_res == expv)
        else report_fail($sformatf("FAIL at %0t: base %0d key %h gave %0d, expected %0d",
                                   $time, jobv.base, jobv.key, o_res, expv));
    end
  end

  initial begin : watchdog
    repeat (TOTAL_JOBS * `NUM_LANES * 600 + 1000) @(posedge clk);
    report_fail("Timeout: results stopped arriving before all jobs completed");
  end

  initial begin
    clk      = 1'b0;
    i_rst    = 1'b1;
    i_val    = 1'b0;
    i_base   = '0;
    i_key    = '0;
    i_rdy    = 1'b1;
    bp_on    = 1'b0;
    job_seed = 32'd73;
    rdy_seed = xorshift32(32'd73);

    // Reset state
    repeat (10) begin
      @(posedge clk);
      #1;
      assert (o_val == 1'b0)
        else report_fail($sformatf("FAIL at %0t: o_val high during reset", $time));
    end
    i_rst = 1'b0;
    assert (o_rdy == 1'b1)
      else report_fail($sformatf("FAIL at %0t: o_rdy low in first cycle after reset", $time));

    // Edge keys
    send_job(16'd0, 16'h0000);
    send_job(16'd1, 16'h0000);
    send_job(16'd12345, 16'h0000);
    send_job(16'd65520, 16'h0000);
    send_job(16'd0, 16'h0001);
    send_job(16'd2, 16'h0001);
    send_job(16'd40000, 16'h0001);
    send_job(16'd65520, 16'h0001);
    send_job(16'd0, 16'h0002);
    send_job(16'd0, 16'h8000);
    send_job(16'd0, 16'hFFFF);

    // Extreme operands
    send_job(16'd65520, 16'hFFFF);
    send_job(16'd65520, 16'h8000);
    send_job(16'd1, 16'hFFFF);
    send_job(16'd2, 16'hFFFF);
    for (int i = 8; i < `KEY_BITS; i++) begin
      send_job(16'd3, key_t'(1) << i);  // Single high bit
    end

    // Back-to-back random jobs, output always ready
    repeat (N_RANDOM) send_random_job();

    // Random back-pressure and input gaps
    bp_on = 1'b1;
    repeat (N_RANDOM) begin
      send_random_job();
      job_seed = xorshift32(job_seed);
      if (job_seed[1:0] == 2'd0) idle_cycles(int'(job_seed[5:2]));
    end

    // Drain, then watch for stray results
    while (exp_q.size() != 0) @(posedge clk);
    bp_on = 1'b0;
    repeat (50) @(posedge clk);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
